// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing
TOP        = icache_tb
FILELIST   = sources.f
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = Something failed
PASS_MSG   = Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@echo "Simulation passed"

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sources.f ====
src/icache_pkg.sv
src/icache_controller.sv
src/icache_store.sv
src/icache_refill.sv
src/icache_top.sv
test/tb_clock_gen.sv
test/icache_mem_model.sv
test/icache_assert.sv
test/icache_tb.sv

// ==== src/icache_controller.sv ====
`timescale 1ns/1ps

module icache_controller (
  input  logic clk_i,
  input  logic rst_ni,

  // Fetch stage side
  input  logic fetch_req_i,
  input  logic fetch_kill_i,
  output logic fetch_ack_o,

  // Line store
  input  logic hit_i,

  // Refill engine
  input  logic refill_done_i,
  input  logic refill_idle_i,
  output logic refill_start_o,
  output logic refill_abort_o
);

  import icache_pkg::*;

  icache_state_e state_q;
  icache_state_e state_d;
  logic          ack_d;
  logic          req_live;

  // A request counts only while it is not being killed and has not been answered
  assign req_live = fetch_req_i & ~fetch_kill_i & ~fetch_ack_o;

  always_comb begin
    state_d        = state_q;
    refill_start_o = 1'b0;
    refill_abort_o = 1'b0;

    unique case (state_q)
      ICACHE_IDLE: begin
        // Miss starts a line refill
        if (req_live && !hit_i) begin
          refill_start_o = 1'b1;
          state_d        = ICACHE_READ_MEMORY;
        end
      end

      ICACHE_READ_MEMORY: begin
        if (fetch_kill_i) begin
          // Let the refill engine finish its beat, then stop
          refill_abort_o = 1'b1;
          state_d        = ICACHE_DRAIN;
        end else if (refill_done_i) begin
          // Line is valid now, the held request hits in idle
          state_d = ICACHE_IDLE;
        end
      end

      ICACHE_DRAIN: begin
        refill_abort_o = 1'b1;
        if (refill_idle_i) begin
          state_d = ICACHE_IDLE;
        end
      end

      default: begin
        state_d = ICACHE_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= ICACHE_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Hits are answered only from idle, and never twice in a row
  assign ack_d = (state_q == ICACHE_IDLE) & req_live & hit_i;

  // Registered single-cycle acknowledge towards fetch
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      fetch_ack_o <= 1'b0;
    end else begin
      fetch_ack_o <= ack_d;
    end
  end

endmodule

// ==== src/icache_pkg.sv ====
package icache_pkg;

  // Top level FSM of the cache controller
  typedef enum logic [1:0] {
    // Waiting for a fetch request, hits are served from here
    ICACHE_IDLE        = 2'b00,
    // A line refill is running in the refill engine
    ICACHE_READ_MEMORY = 2'b01,
    // Refill was killed, wait until the current beat has finished
    ICACHE_DRAIN       = 2'b10
  } icache_state_e;

  // Four-phase handshake FSM of the refill engine
  typedef enum logic [1:0] {
    REFILL_IDLE    = 2'b00,
    // Request held high until memory raises ack
    REFILL_REQ     = 2'b01,
    // Request low, wait for memory to drop ack
    REFILL_RELEASE = 2'b10
  } refill_state_e;

  // Word address width, the fetch stage addresses whole instructions
  localparam int ADDR_WIDTH_DEF = 16;

  // Instruction width
  localparam int DATA_WIDTH_DEF = 32;

  // Words in one cache line, power of two
  localparam int LINE_WORDS_DEF = 4;

  // Lines in the cache, power of two
  localparam int NUM_LINES_DEF = 8;

endpackage

// ==== src/icache_refill.sv ====
`timescale 1ns/1ps

module icache_refill #(
  parameter int ADDR_WIDTH = icache_pkg::ADDR_WIDTH_DEF,
  parameter int DATA_WIDTH = icache_pkg::DATA_WIDTH_DEF,
  parameter int LINE_WORDS = icache_pkg::LINE_WORDS_DEF
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  // Control from the cache controller
  input  logic                          start_i,
  input  logic                          abort_i,
  input  logic [ADDR_WIDTH-1:0]         line_addr_i,

  // Four-phase memory port
  output logic                          mem_req_o,
  output logic [ADDR_WIDTH-1:0]         mem_addr_o,
  input  logic                          mem_ack_i,
  input  logic [DATA_WIDTH-1:0]         mem_data_i,

  // Line fill towards the store
  output logic                          fill_we_o,
  output logic [$clog2(LINE_WORDS)-1:0] fill_word_idx_o,
  output logic [DATA_WIDTH-1:0]         fill_data_o,

  output logic                          done_o,
  output logic                          idle_o
);

  import icache_pkg::*;

  localparam int OFF_W  = $clog2(LINE_WORDS);
  localparam int LINE_W = ADDR_WIDTH - OFF_W;

  refill_state_e         state_q;
  refill_state_e         state_d;
  logic [LINE_W-1:0]     line_q;
  logic [OFF_W-1:0]      beat_q;
  logic [DATA_WIDTH-1:0] data_q;
  logic                  abort_q;

  logic                  launch;
  logic                  abort_any;
  logic                  last_beat;
  logic                  beat_end;

  assign launch    = start_i && (state_q == REFILL_IDLE);
  assign abort_any = abort_q | abort_i;
  assign last_beat = beat_q == OFF_W'(LINE_WORDS - 1);
  // A beat is complete once memory has dropped ack again
  assign beat_end  = (state_q == REFILL_RELEASE) && !mem_ack_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      REFILL_IDLE: begin
        if (start_i) begin
          state_d = REFILL_REQ;
        end
      end
      REFILL_REQ: begin
        if (mem_ack_i) begin
          state_d = REFILL_RELEASE;
        end
      end
      REFILL_RELEASE: begin
        if (!mem_ack_i) begin
          state_d = (abort_any || last_beat) ? REFILL_IDLE : REFILL_REQ;
        end
      end
      default: begin
        state_d = REFILL_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= REFILL_IDLE;
      beat_q  <= '0;
      abort_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (launch) begin
        beat_q  <= '0;
        abort_q <= 1'b0;
      end else begin
        if (beat_end) begin
          beat_q <= beat_q + 1'b1;
        end
        // Abort is only remembered while a refill runs
        if (abort_i && (state_q != REFILL_IDLE)) begin
          abort_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (launch) begin
      line_q <= line_addr_i[ADDR_WIDTH-1:OFF_W];
    end
    if ((state_q == REFILL_REQ) && mem_ack_i) begin
      data_q <= mem_data_i;
    end
  end

  assign mem_req_o  = state_q == REFILL_REQ;
  assign mem_addr_o = {line_q, beat_q};

  // Aborted beats are not written, the fetch address may already point elsewhere
  assign fill_we_o       = beat_end && !abort_any;
  assign fill_word_idx_o = beat_q;
  assign fill_data_o     = data_q;

  assign done_o = fill_we_o && last_beat;
  assign idle_o = state_q == REFILL_IDLE;

endmodule

// ==== src/icache_store.sv ====
`timescale 1ns/1ps

module icache_store #(
  parameter int ADDR_WIDTH = icache_pkg::ADDR_WIDTH_DEF,
  parameter int DATA_WIDTH = icache_pkg::DATA_WIDTH_DEF,
  parameter int LINE_WORDS = icache_pkg::LINE_WORDS_DEF,
  parameter int NUM_LINES  = icache_pkg::NUM_LINES_DEF
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  // Word address from fetch, also selects the line being filled
  input  logic [ADDR_WIDTH-1:0]         fetch_addr_i,

  // Line fill port from the refill engine
  input  logic                          fill_we_i,
  input  logic [$clog2(LINE_WORDS)-1:0] fill_word_idx_i,
  input  logic [DATA_WIDTH-1:0]         fill_data_i,

  output logic                          hit_o,
  output logic [DATA_WIDTH-1:0]         fetch_data_o
);

  localparam int OFF_W = $clog2(LINE_WORDS);
  localparam int IDX_W = $clog2(NUM_LINES);
  localparam int TAG_W = ADDR_WIDTH - OFF_W - IDX_W;

  logic [OFF_W-1:0]      addr_off;
  logic [IDX_W-1:0]      addr_idx;
  logic [TAG_W-1:0]      addr_tag;

  logic                  valid_q [NUM_LINES];
  logic [TAG_W-1:0]      tag_mem [NUM_LINES];
  logic [DATA_WIDTH-1:0] data_mem [NUM_LINES][LINE_WORDS];

  logic                  fill_first;
  logic                  fill_last;

  // Address split: tag | index | word offset
  assign addr_off = fetch_addr_i[OFF_W-1:0];
  assign addr_idx = fetch_addr_i[OFF_W+IDX_W-1:OFF_W];
  assign addr_tag = fetch_addr_i[ADDR_WIDTH-1:OFF_W+IDX_W];

  assign fill_first = fill_we_i && (fill_word_idx_i == '0);
  assign fill_last  = fill_we_i && (fill_word_idx_i == OFF_W'(LINE_WORDS - 1));

  // Tag compare
  assign hit_o = valid_q[addr_idx] && (tag_mem[addr_idx] == addr_tag);

  // Valid bits: dropped when a new fill begins, set with the last word
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_LINES; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (fill_last) begin
      valid_q[addr_idx] <= 1'b1;
    end else if (fill_first) begin
      valid_q[addr_idx] <= 1'b0;
    end
  end

  // Tag is taken on the first beat of a fill
  always_ff @(posedge clk_i) begin
    if (fill_first) begin
      tag_mem[addr_idx] <= addr_tag;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_we_i) begin
      data_mem[addr_idx][fill_word_idx_i] <= fill_data_i;
    end
  end

  // Read word is registered so it lines up with the registered ack
  always_ff @(posedge clk_i) begin
    fetch_data_o <= data_mem[addr_idx][addr_off];
  end

endmodule

// ==== src/icache_top.sv ====
`timescale 1ns/1ps

module icache_top #(
  parameter int ADDR_WIDTH = icache_pkg::ADDR_WIDTH_DEF,
  parameter int DATA_WIDTH = icache_pkg::DATA_WIDTH_DEF,
  parameter int LINE_WORDS = icache_pkg::LINE_WORDS_DEF,
  parameter int NUM_LINES  = icache_pkg::NUM_LINES_DEF
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // Fetch stage
  input  logic                  fetch_req_i,
  input  logic [ADDR_WIDTH-1:0] fetch_addr_i,
  input  logic                  fetch_kill_i,
  output logic                  fetch_ack_o,
  output logic [DATA_WIDTH-1:0] fetch_data_o,

  // Instruction memory
  output logic                  mem_req_o,
  output logic [ADDR_WIDTH-1:0] mem_addr_o,
  input  logic                  mem_ack_i,
  input  logic [DATA_WIDTH-1:0] mem_data_i
);

  localparam int OFF_W = $clog2(LINE_WORDS);

  logic                  hit;
  logic                  refill_start;
  logic                  refill_abort;
  logic                  refill_done;
  logic                  refill_idle;
  logic                  fill_we;
  logic [OFF_W-1:0]      fill_word_idx;
  logic [DATA_WIDTH-1:0] fill_data;

  icache_controller u_controller (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_req_i    (fetch_req_i),
    .fetch_kill_i   (fetch_kill_i),
    .fetch_ack_o    (fetch_ack_o),
    .hit_i          (hit),
    .refill_done_i  (refill_done),
    .refill_idle_i  (refill_idle),
    .refill_start_o (refill_start),
    .refill_abort_o (refill_abort)
  );

  icache_store #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .LINE_WORDS (LINE_WORDS),
    .NUM_LINES  (NUM_LINES)
  ) u_store (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .fetch_addr_i    (fetch_addr_i),
    .fill_we_i       (fill_we),
    .fill_word_idx_i (fill_word_idx),
    .fill_data_i     (fill_data),
    .hit_o           (hit),
    .fetch_data_o    (fetch_data_o)
  );

  // Line base is taken from the fetch address that missed
  icache_refill #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .LINE_WORDS (LINE_WORDS)
  ) u_refill (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .start_i         (refill_start),
    .abort_i         (refill_abort),
    .line_addr_i     (fetch_addr_i),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .mem_ack_i       (mem_ack_i),
    .mem_data_i      (mem_data_i),
    .fill_we_o       (fill_we),
    .fill_word_idx_o (fill_word_idx),
    .fill_data_o     (fill_data),
    .done_o          (refill_done),
    .idle_o          (refill_idle)
  );

endmodule

// ==== test/icache_assert.sv ====
`timescale 1ns/1ps

module icache_assert (
  input logic clk_i,
  input logic rst_ni,
  input logic fetch_req_i,
  input logic fetch_ack_i,
  input logic mem_req_i,
  input logic mem_ack_i
);

  // Acknowledge towards fetch is a one-cycle pulse
  ack_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_ack_i |=> !fetch_ack_i)
    else $error("fetch_ack_o was high in two consecutive cycles");

  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_ack_i |-> $past(fetch_req_i))
    else $error("fetch_ack_o without a fetch request");

  // Four-phase ordering on the memory port
  req_rise_ack_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(mem_req_i) |-> !mem_ack_i)
    else $error("mem_req_o rose while mem_ack_i was still high");

  req_held_until_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_i && !mem_ack_i) |=> mem_req_i)
    else $error("mem_req_o dropped before mem_ack_i");

  reset_outputs_low: assert property (@(posedge clk_i)
    !rst_ni |=> (!fetch_ack_i && !mem_req_i))
    else $error("fetch_ack_o or mem_req_o high during reset");

endmodule

bind icache_top icache_assert u_assert (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .fetch_req_i (fetch_req_i),
  .fetch_ack_i (fetch_ack_o),
  .mem_req_i   (mem_req_o),
  .mem_ack_i   (mem_ack_i)
);

// ==== test/icache_mem_model.sv ====
`timescale 1ns/1ps

module icache_mem_model #(
  parameter int                    ADDR_WIDTH = 16,
  parameter int                    DATA_WIDTH = 32,
  parameter logic [DATA_WIDTH-1:0] DATA_KEY   = '0,
  parameter int                    MAX_DELAY  = 3
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  mem_req_i,
  input  logic [ADDR_WIDTH-1:0] mem_addr_i,
  output logic                  mem_ack_o,
  output logic [DATA_WIDTH-1:0] mem_data_o
);

  integer seed;
  int     delay;

  initial begin
    seed       = 32'hfd21_6782;
    mem_ack_o  = 1'b0;
    mem_data_o = '0;
    forever begin
      @(posedge clk_i);
      if (rst_ni && mem_req_i) begin
        // Access time before the word comes back
        delay = $unsigned($random(seed)) % (MAX_DELAY + 1);
        repeat (delay) @(posedge clk_i);
        mem_ack_o  <= 1'b1;
        mem_data_o <= DATA_WIDTH'(mem_addr_i) ^ DATA_KEY;
        // Ack stays up until the request is gone
        @(posedge clk_i);
        while (mem_req_i) begin
          @(posedge clk_i);
        end
        delay = $unsigned($random(seed)) % (MAX_DELAY + 1);
        repeat (delay) @(posedge clk_i);
        mem_ack_o <= 1'b0;
      end
    end
  end

endmodule

// ==== test/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb;

  import icache_pkg::*;

  localparam int ADDR_WIDTH = ADDR_WIDTH_DEF;
  localparam int DATA_WIDTH = DATA_WIDTH_DEF;
  localparam int LINE_WORDS = LINE_WORDS_DEF;
  localparam int NUM_LINES  = NUM_LINES_DEF;
  localparam logic [DATA_WIDTH-1:0] DATA_KEY = 32'h3c5a_a5c3;

  localparam int MAX_DELAY    = 3;
  localparam int RESET_CYCLES = 10;
  localparam int QUIET_CYCLES = 12;
  localparam int MIN_MISS     = 3 * LINE_WORDS + 2;
  localparam int WORST_MISS   = LINE_WORDS * (4 + 2 * MAX_DELAY) + 4;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [7:0]            kill_after;
    logic                  exp_hit;
    logic [7:0]            exp_beats;
  } row_t;

  localparam int NUM_ROWS       = 15;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ROWS * (WORST_MISS + QUIET_CYCLES + 4);

  // Address, kill after cycles (0 none), hit, beats (upper bound on killed rows)
  localparam row_t ROWS [NUM_ROWS] = '{
    '{16'h0000, 8'd0,  1'b0, 8'd4}, '{16'h0001, 8'd0, 1'b1, 8'd0},
    '{16'h0004, 8'd0,  1'b0, 8'd4}, '{16'h0006, 8'd0, 1'b1, 8'd0},
    // Same index as line 0 with a different tag
    '{16'h0022, 8'd0,  1'b0, 8'd4}, '{16'h0002, 8'd0, 1'b0, 8'd4},
    '{16'h0021, 8'd0,  1'b0, 8'd4}, '{16'h0023, 8'd0, 1'b1, 8'd0},
    '{16'h1234, 8'd4,  1'b0, 8'd4}, '{16'h1234, 8'd0, 1'b0, 8'd4},
    '{16'h1235, 8'd0,  1'b1, 8'd0}, '{16'h0318, 8'd10, 1'b0, 8'd4},
    '{16'h0318, 8'd0,  1'b0, 8'd4}, '{16'h031b, 8'd0, 1'b1, 8'd0},
    '{16'h0005, 8'd0,  1'b1, 8'd0}
  };

  logic                  clk;
  logic                  rst_n;
  logic                  fetch_req;
  logic [ADDR_WIDTH-1:0] fetch_addr;
  logic                  fetch_kill;
  logic                  fetch_ack;
  logic [DATA_WIDTH-1:0] fetch_data;
  logic                  mem_req;
  logic [ADDR_WIDTH-1:0] mem_addr;
  logic                  mem_ack;
  logic [DATA_WIDTH-1:0] mem_data;
  logic [ADDR_WIDTH-1:0] beat_addrs [$];

  tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(RESET_CYCLES)) u_clock (
    .clk_o (clk), .rst_no (rst_n)
  );

  icache_mem_model #(
    .ADDR_WIDTH (ADDR_WIDTH), .DATA_WIDTH (DATA_WIDTH),
    .DATA_KEY   (DATA_KEY),   .MAX_DELAY  (MAX_DELAY)
  ) u_mem (
    .clk_i (clk), .rst_ni (rst_n), .mem_req_i (mem_req), .mem_addr_i (mem_addr),
    .mem_ack_o (mem_ack), .mem_data_o (mem_data)
  );

  icache_top #(
    .ADDR_WIDTH (ADDR_WIDTH), .DATA_WIDTH (DATA_WIDTH),
    .LINE_WORDS (LINE_WORDS), .NUM_LINES  (NUM_LINES)
  ) DUT (
    .clk_i (clk), .rst_ni (rst_n), .fetch_req_i (fetch_req), .fetch_addr_i (fetch_addr),
    .fetch_kill_i (fetch_kill), .fetch_ack_o (fetch_ack), .fetch_data_o (fetch_data),
    .mem_req_o (mem_req), .mem_addr_o (mem_addr), .mem_ack_i (mem_ack), .mem_data_i (mem_data)
  );

  // One entry per memory handshake
  always @(negedge clk) begin
    if (rst_n && mem_req && mem_ack) begin
      beat_addrs.push_back(mem_addr);
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  task automatic run_row(input int n);
    row_t                  r;
    int                    cycles;
    logic                  got_ack;
    logic                  killed;
    logic [ADDR_WIDTH-1:0] base;
    r       = ROWS[n];
    cycles  = 0;
    got_ack = 1'b0;
    killed  = 1'b0;
    base    = r.addr & ~ADDR_WIDTH'(LINE_WORDS - 1);
    @(posedge clk);
    beat_addrs.delete();
    fetch_req  <= 1'b1;
    fetch_addr <= r.addr;
    while (!got_ack && !killed) begin
      @(posedge clk);
      cycles++;
      if (r.kill_after != 8'd0 && cycles == int'(r.kill_after)) begin
        fetch_kill <= 1'b1;
        fetch_req  <= 1'b0;
        killed = 1'b1;
      end
      @(negedge clk);
      got_ack = fetch_ack;
    end
    if (killed) begin
      check_value("fetch_ack_o", 64'(got_ack), 64'(0));
      @(posedge clk);
      fetch_kill <= 1'b0;
      // Current beat completes, then the memory port stays idle
      do begin
        @(negedge clk);
        check_value("fetch_ack_o", 64'(fetch_ack), 64'(0));
      end while (mem_req || mem_ack);
      repeat (QUIET_CYCLES) begin
        @(negedge clk);
        check_value("mem_req_o", 64'(mem_req), 64'(0));
        check_value("fetch_ack_o", 64'(fetch_ack), 64'(0));
      end
      check_value("beat_count_in_range",
                  64'(beat_addrs.size() >= 1 && beat_addrs.size() <= int'(r.exp_beats)), 64'(1));
    end else begin
      check_value("fetch_data_o", 64'(fetch_data), 64'(DATA_WIDTH'(r.addr) ^ DATA_KEY));
      if (r.exp_hit) begin
        check_value("hit_latency", 64'(cycles), 64'(1));
      end else begin
        check_value("miss_latency_at_least_min", 64'(cycles >= MIN_MISS), 64'(1));
      end
      // Request is still up at this edge and no second ack may follow
      @(posedge clk);
      fetch_req <= 1'b0;
      @(negedge clk);
      check_value("fetch_ack_o", 64'(fetch_ack), 64'(0));
      check_value("beat_count", 64'(beat_addrs.size()), 64'(r.exp_beats));
    end
    foreach (beat_addrs[i]) begin
      check_value("mem_addr_o", 64'(beat_addrs[i]), 64'(base + ADDR_WIDTH'(i)));
    end
  endtask

  initial begin
    fetch_req  = 1'b0;
    fetch_addr = '0;
    fetch_kill = 1'b0;
    @(posedge rst_n);
    for (int n = 0; n < NUM_ROWS; n++) begin
      run_row(n);
    end
    $display("Everything OK");
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Something failed");
    $fatal(1);
  end

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset released on a rising edge after the hold time
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule
